/* Bender.yml */
package:
  name: rvCore

sources:
  - logic/rvPkg.sv
  - logic/controlMain.sv
  - logic/aluExecute.sv
  - logic/resultWriteback.sv
  - logic/wbHostPort.sv
  - logic/rvCoreTop.sv
  - target: test
    files:
      - verification/rvCoreChecker.sv
      - verification/rvCoreTb.sv

/* logic/aluExecute.sv */
`timescale 1ns/100ps

module aluExecute (
	input rvPkg::instrU instr,
	input logic [31:0] rs1Data,
	input logic [31:0] rs2Data,
	input logic [31:0] pc,
	input logic aluSrc,
	input logic inAIsPc,
	input logic branch,
	input logic jump,
	input logic jumpReg,
	input rvPkg::aluCtrlE aluCtrl,
	output logic [31:0] aluResult,
	output logic [31:0] nextPc
);

	logic [31:0] imm; // sign extended, per format
	logic [31:0] inA;
	logic [31:0] inB;
	logic [31:0] opResult;
	logic signed [31:0] sraResult;
	logic [31:0] pcPlus4;
	logic [2:0] funct3;
	logic isSub;
	logic isArith;
	logic takeBranch;

	always_comb begin
		case (instr.rFmt.opcode)
			rvPkg::opStore: imm = {{20{instr.sFmt.immHi[6]}}, instr.sFmt.immHi,
				instr.sFmt.immLo};
			rvPkg::opBranch: imm = {{19{instr.bFmt.imm12}}, instr.bFmt.imm12,
				instr.bFmt.imm11, instr.bFmt.imm10to5, instr.bFmt.imm4to1, 1'b0};
			rvPkg::opLui, rvPkg::opAuipc: imm = {instr.uFmt.imm, 12'b0};
			rvPkg::opJal: imm = {{11{instr.jFmt.imm20}}, instr.jFmt.imm20,
				instr.jFmt.imm19to12, instr.jFmt.imm11, instr.jFmt.imm10to1, 1'b0};
			default: imm = {{20{instr.iFmt.imm[11]}}, instr.iFmt.imm};
		endcase
	end

	assign inA = inAIsPc ? pc : rs1Data;
	assign inB = aluSrc ? imm : rs2Data;
	assign pcPlus4 = pc + 32'd4;
	assign funct3 = instr.rFmt.funct3;
	assign isSub = (aluCtrl == rvPkg::aluR) && instr.rFmt.funct7[5]; // addi has no sub
	assign isArith = instr.rFmt.funct7[5]; // imm[10] for srai
	assign sraResult = $signed(inA) >>> inB[4:0];

	always_comb begin
		case (funct3)
			rvPkg::f3AddSub: opResult = isSub ? inA - inB : inA + inB;
			rvPkg::f3Sll: opResult = inA << inB[4:0];
			rvPkg::f3Slt: opResult = {31'b0, $signed(inA) < $signed(inB)};
			rvPkg::f3Sltu: opResult = {31'b0, inA < inB};
			rvPkg::f3Xor: opResult = inA ^ inB;
			rvPkg::f3Srl: opResult = isArith ? sraResult : inA >> inB[4:0];
			rvPkg::f3Or: opResult = inA | inB;
			default: opResult = inA & inB;
		endcase
	end

	always_comb begin
		case (aluCtrl)
			rvPkg::aluR, rvPkg::aluIComp: aluResult = opResult;
			rvPkg::aluJ: aluResult = pcPlus4; // link
			rvPkg::aluLui: aluResult = imm;
			default: aluResult = inA + inB; // address or auipc sum
		endcase
	end

	always_comb begin
		case (instr.bFmt.funct3)
			rvPkg::f3Beq: takeBranch = rs1Data == rs2Data;
			rvPkg::f3Bne: takeBranch = rs1Data != rs2Data;
			rvPkg::f3Blt: takeBranch = $signed(rs1Data) < $signed(rs2Data);
			rvPkg::f3Bge: takeBranch = $signed(rs1Data) >= $signed(rs2Data);
			rvPkg::f3Bltu: takeBranch = rs1Data < rs2Data;
			rvPkg::f3Bgeu: takeBranch = rs1Data >= rs2Data;
			default: takeBranch = 1'b0;
		endcase
	end

	always_comb begin
		if (jumpReg)
			nextPc = (rs1Data + imm) & ~32'd1;
		else if (jump || (branch && takeBranch))
			nextPc = pc + imm;
		else
			nextPc = pcPlus4;
	end

	// an aligned pc and offset must give an aligned target
	branchTargetAligned: assert final (!(branch && pc[1:0] == 2'b00 && imm[1] == 1'b0)
		|| nextPc[1:0] == 2'b00);

endmodule

/* logic/controlMain.sv */
`timescale 1ns/100ps

module controlMain (
	input logic [6:0] opcode,
	output logic regWrite,
	output logic memRead,
	output logic memWrite,
	output logic memToReg,
	output logic aluSrc,
	output logic branch,
	output logic jump,
	output logic jumpReg,
	output logic inAIsPc,
	output rvPkg::aluCtrlE aluCtrl
);

	always_comb begin
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		aluSrc = 1'b0;
		branch = 1'b0;
		jump = 1'b0;
		jumpReg = 1'b0;
		inAIsPc = 1'b0;
		aluCtrl = rvPkg::aluR;
		case (opcode)
			rvPkg::opR: begin
				regWrite = 1'b1;
			end
			rvPkg::opIComp: begin
				regWrite = 1'b1;
				aluSrc = 1'b1;
				aluCtrl = rvPkg::aluIComp;
			end
			rvPkg::opLoad: begin
				regWrite = 1'b1;
				memRead = 1'b1;
				memToReg = 1'b1;
				aluSrc = 1'b1;
				aluCtrl = rvPkg::aluLoadStore;
			end
			rvPkg::opStore: begin
				memWrite = 1'b1;
				aluSrc = 1'b1;
				aluCtrl = rvPkg::aluLoadStore;
			end
			rvPkg::opBranch: begin
				branch = 1'b1;
				aluCtrl = rvPkg::aluBranch;
			end
			rvPkg::opJal: begin
				regWrite = 1'b1;
				jump = 1'b1;
				inAIsPc = 1'b1; // link value built from pc
				aluCtrl = rvPkg::aluJ;
			end
			rvPkg::opJalr: begin
				regWrite = 1'b1;
				jumpReg = 1'b1;
				inAIsPc = 1'b1;
				aluCtrl = rvPkg::aluJ;
			end
			rvPkg::opLui: begin
				regWrite = 1'b1;
				aluSrc = 1'b1;
				aluCtrl = rvPkg::aluLui;
			end
			rvPkg::opAuipc: begin
				regWrite = 1'b1;
				aluSrc = 1'b1;
				inAIsPc = 1'b1;
				aluCtrl = rvPkg::aluAuipc;
			end
			default: ; // unknown opcode, nothing but pc+4
		endcase
	end

	memAccessOneHot: assert final (!(memRead && memWrite));

endmodule

/* logic/resultWriteback.sv */
`timescale 1ns/100ps

module resultWriteback (
	input logic clk,
	input logic rstN,
	input logic commit,
	input rvPkg::instrU instr,
	input logic regWrite,
	input logic memWrite,
	input logic memToReg,
	input logic [31:0] aluResult,
	input logic [31:0] nextPc,
	input logic pcWrite,
	input logic [31:0] pcWrData,
	input logic [4:0] regRdIdx,
	output logic [31:0] rs1Data,
	output logic [31:0] rs2Data,
	output logic [31:0] regRdData,
	output logic [31:0] pcValue
);

	logic [31:0] regs [32];
	logic [31:0] ram [rvPkg::dataWords];
	logic [31:0] pc;
	logic [$clog2(rvPkg::dataWords)-1:0] ramIdx;
	logic [31:0] wrData;
	logic [4:0] rd;

	assign rd = instr.rFmt.rd;
	assign ramIdx = aluResult[$clog2(rvPkg::dataWords)+1:2]; // wraps
	assign wrData = memToReg ? ram[ramIdx] : aluResult;

	assign rs1Data = regs[instr.rFmt.rs1];
	assign rs2Data = regs[instr.rFmt.rs2];
	assign regRdData = regs[regRdIdx];
	assign pcValue = pc;

	// x0 is cleared by reset and never written
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int k = 0; k < 32; k++) begin
				regs[k] <= '0;
			end
		end else if (commit && regWrite && rd != 5'd0) begin
			regs[rd] <= wrData;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int k = 0; k < rvPkg::dataWords; k++) begin
				ram[k] <= '0;
			end
		end else if (commit && memWrite) begin
			ram[ramIdx] <= rs2Data;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
		end else if (commit) begin
			pc <= nextPc;
		end else if (pcWrite) begin
			pc <= pcWrData; // host write
		end
	end

	// the host port never issues both in one ack cycle
	commitPcWriteExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(commit && pcWrite));

endmodule

/* logic/rvCoreTop.sv */
`timescale 1ns/100ps

module rvCoreTop (
	input logic clk,
	input logic rstN,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [5:0] adr,
	input logic [31:0] datIn,
	output logic [31:0] datOut,
	output logic ack
);

	rvPkg::instrU instr;
	rvPkg::aluCtrlE aluCtrl;
	logic commit;
	logic pcWrite;
	logic [31:0] pcWrData;
	logic [4:0] regRdIdx;
	logic [31:0] pcValue;
	logic [31:0] regRdData;
	logic regWrite;
	logic memWrite;
	logic memToReg;
	logic aluSrc;
	logic branch;
	logic jump;
	logic jumpReg;
	logic inAIsPc;
	logic [31:0] rs1Data;
	logic [31:0] rs2Data;
	logic [31:0] aluResult;
	logic [31:0] nextPc;

	wbHostPort wbHostPort_inst (
		.clk(clk), .rstN(rstN), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.datIn(datIn), .datOut(datOut), .ack(ack), .instr(instr), .commit(commit),
		.pcWrite(pcWrite), .pcWrData(pcWrData), .regRdIdx(regRdIdx),
		.pcValue(pcValue), .regRdData(regRdData)
	);

	controlMain controlMain_inst (
		.opcode(instr.rFmt.opcode), .regWrite(regWrite),
		.memRead(), // loads already select through memToReg
		.memWrite(memWrite), .memToReg(memToReg), .aluSrc(aluSrc), .branch(branch),
		.jump(jump), .jumpReg(jumpReg), .inAIsPc(inAIsPc), .aluCtrl(aluCtrl)
	);

	aluExecute aluExecute_inst (
		.instr(instr), .rs1Data(rs1Data), .rs2Data(rs2Data), .pc(pcValue),
		.aluSrc(aluSrc), .inAIsPc(inAIsPc), .branch(branch), .jump(jump),
		.jumpReg(jumpReg), .aluCtrl(aluCtrl), .aluResult(aluResult), .nextPc(nextPc)
	);

	resultWriteback resultWriteback_inst (
		.clk(clk), .rstN(rstN), .commit(commit), .instr(instr), .regWrite(regWrite),
		.memWrite(memWrite), .memToReg(memToReg), .aluResult(aluResult),
		.nextPc(nextPc), .pcWrite(pcWrite), .pcWrData(pcWrData), .regRdIdx(regRdIdx),
		.rs1Data(rs1Data), .rs2Data(rs2Data), .regRdData(regRdData), .pcValue(pcValue)
	);

endmodule

/* logic/rvPkg.sv */
package rvPkg;

	// major opcodes, instr[6:0]
	localparam logic [6:0] opR = 7'b0110011;
	localparam logic [6:0] opIComp = 7'b0010011;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal = 7'b1101111;
	localparam logic [6:0] opJalr = 7'b1100111;
	localparam logic [6:0] opLui = 7'b0110111;
	localparam logic [6:0] opAuipc = 7'b0010111;

	// funct3 for R and I-compare operations
	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Sll = 3'b001;
	localparam logic [2:0] f3Slt = 3'b010;
	localparam logic [2:0] f3Sltu = 3'b011;
	localparam logic [2:0] f3Xor = 3'b100;
	localparam logic [2:0] f3Srl = 3'b101; // also sra, split by funct7[5]
	localparam logic [2:0] f3Or = 3'b110;
	localparam logic [2:0] f3And = 3'b111;

	// funct3 for branches
	localparam logic [2:0] f3Beq = 3'b000;
	localparam logic [2:0] f3Bne = 3'b001;
	localparam logic [2:0] f3Blt = 3'b100;
	localparam logic [2:0] f3Bge = 3'b101;
	localparam logic [2:0] f3Bltu = 3'b110;
	localparam logic [2:0] f3Bgeu = 3'b111;

	typedef enum logic [2:0] {
		aluR,
		aluIComp,
		aluLoadStore,
		aluBranch,
		aluJ,
		aluLui,
		aluAuipc
	} aluCtrlE;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rFmtS;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} iFmtS;

	typedef struct packed {
		logic [6:0] immHi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		logic [6:0] opcode;
	} sFmtS;

	typedef struct packed {
		logic imm12;
		logic [5:0] imm10to5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4to1;
		logic imm11;
		logic [6:0] opcode;
	} bFmtS;

	typedef struct packed {
		logic [19:0] imm; // goes to bits 31:12
		logic [4:0] rd;
		logic [6:0] opcode;
	} uFmtS;

	typedef struct packed {
		logic imm20;
		logic [9:0] imm10to1;
		logic imm11;
		logic [7:0] imm19to12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} jFmtS;

	typedef union packed {
		rFmtS rFmt;
		iFmtS iFmt;
		sFmtS sFmt;
		bFmtS bFmt;
		uFmtS uFmt;
		jFmtS jFmt;
	} instrU;

	// host word addresses
	localparam logic [5:0] adrInstr = 6'd0; // write only
	localparam logic [5:0] adrPc = 6'd1;
	localparam logic [5:0] adrRegBase = 6'd32; // x0..x31 at 32..63

	localparam int dataWords = 16;

endpackage

/* logic/wbHostPort.sv */
`timescale 1ns/100ps

module wbHostPort (
	input logic clk,
	input logic rstN,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [5:0] adr,
	input logic [31:0] datIn,
	output logic [31:0] datOut,
	output logic ack,
	output rvPkg::instrU instr,
	output logic commit,
	output logic pcWrite,
	output logic [31:0] pcWrData,
	output logic [4:0] regRdIdx,
	input logic [31:0] pcValue,
	input logic [31:0] regRdData
);

	logic req;
	logic instrWr;
	logic pcWr;
	logic [31:0] rdData;

	assign req = cyc && stb && !ack; // new transfer this cycle
	assign instrWr = req && we && adr == rvPkg::adrInstr;
	assign pcWr = req && we && adr == rvPkg::adrPc;
	assign regRdIdx = adr[4:0];

	always_comb begin
		if (adr >= rvPkg::adrRegBase)
			rdData = regRdData;
		else if (adr == rvPkg::adrPc)
			rdData = pcValue;
		else
			rdData = '0; // instr word and unmapped
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			ack <= 1'b0;
			commit <= 1'b0;
			pcWrite <= 1'b0;
		end else begin
			ack <= req;
			commit <= instrWr;
			pcWrite <= pcWr;
		end
	end

	always_ff @(posedge clk) begin
		if (instrWr)
			instr <= datIn;
		if (pcWr)
			pcWrData <= datIn;
		if (req && !we)
			datOut <= rdData; // held through the ack cycle
	end

	// ack answers a request seen at the edge before
	ackInsideCycle: assert property (@(posedge clk) disable iff (!rstN)
		$rose(ack) |-> $past(cyc && stb));

endmodule

/* rvCore.f */
logic/rvPkg.sv
logic/controlMain.sv
logic/aluExecute.sv
logic/resultWriteback.sv
logic/wbHostPort.sv
logic/rvCoreTop.sv
verification/rvCoreChecker.sv
verification/rvCoreTb.sv

/* verification/rvCoreChecker.sv */
`timescale 1ns/100ps

module rvCoreChecker (
	input logic clk,
	input logic rstN,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [5:0] adr,
	input logic [31:0] datOut,
	input logic ack,
	input logic [31:0] expData,
	input logic testEnd,
	input int testIdx,
	output int checkCount,
	output int errCount
);

	logic ackDue; // request seen at the previous edge
	logic readDue;
	logic [5:0] readAdr;
	int testChecks;
	int testErrs;

	function automatic string wordName(input logic [5:0] a);
		if (a >= rvPkg::adrRegBase)
			return $sformatf("x%0d", a - rvPkg::adrRegBase);
		else if (a == rvPkg::adrPc)
			return "pc";
		else
			return $sformatf("adr%0d", a);
	endfunction

	task automatic countCheck(input logic bad);
		checkCount++;
		testChecks++;
		if (bad) begin
			errCount++;
			testErrs++;
		end
	endtask

	initial begin
		checkCount = 0;
		errCount = 0;
		testChecks = 0;
		testErrs = 0;
	end

	always @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			ackDue <= 1'b0;
			readDue <= 1'b0;
			readAdr <= '0;
		end else begin
			if (ackDue || ack) begin
				countCheck(ack !== ackDue);
				if (ack !== ackDue)
					$display("ERR ack at adr %h: got %h expected %h", adr, ack, ackDue);
			end
			if (ackDue && readDue) begin
				countCheck(datOut !== expData);
				if (datOut !== expData)
					$display("ERR datOut (%s): got %h expected %h", wordName(readAdr),
						datOut, expData);
			end
			if (testEnd) begin
				$display("test %0d done: %0d checks, %0d errors", testIdx, testChecks, testErrs);
				testChecks = 0;
				testErrs = 0;
			end
			ackDue <= cyc && stb && !ack;
			readDue <= cyc && stb && !ack && !we;
			if (cyc && stb && !ack)
				readAdr <= adr;
		end
	end

endmodule

/* verification/rvCoreTb.sv */
`timescale 1ns/100ps

module rvCoreTb;

	localparam int aluCount = 200;
	localparam int memCount = 30;
	localparam int flowCount = 40;
	localparam int miscCount = 8;
	// bus transfers over all five tests
	localparam int txTotal = 33 + aluCount * 3 + memCount * 9 + flowCount * 8 + miscCount * 40;
	localparam int cycleLimit = txTotal * 40 + 500;

	logic clk;
	logic rstN;
	logic cyc;
	logic stb;
	logic we;
	logic [5:0] adr;
	logic [31:0] datIn;
	logic [31:0] datOut;
	logic ack;
	logic [31:0] expData;
	logic testEnd;
	int testIdx;
	int checkCount;
	int errCount;
	int cycles = 0;

	logic [31:0] modelRegs [32];
	logic [31:0] modelRam [rvPkg::dataWords];
	logic [31:0] modelPc;
	logic [2:0] branchF3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

	rvCoreTop rvCoreTop_inst (.*);

	rvCoreChecker rvCoreChecker_inst (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			$display("timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic busCycle(input logic write, input logic [5:0] a, input logic [31:0] d,
		input logic [31:0] expVal);
		int waited;
		@(negedge clk);
		expData = expVal;
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = a;
		datIn = d;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!ack && waited < 8);
		if (!ack)
			$display("no ack came for the transfer at adr %h", a);
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic readWord(input logic [5:0] a);
		if (a == rvPkg::adrPc)
			busCycle(1'b0, a, '0, modelPc);
		else if (a >= rvPkg::adrRegBase)
			busCycle(1'b0, a, '0, modelRegs[a[4:0]]);
		else
			busCycle(1'b0, a, '0, '0); // unmapped
	endtask

	task automatic readReg(input logic [4:0] idx);
		readWord(rvPkg::adrRegBase + idx);
	endtask

	task automatic endTest();
		@(negedge clk);
		testEnd = 1'b1;
		@(negedge clk);
		testEnd = 1'b0;
	endtask

	function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: begin
				if (alt)
					return $unsigned($signed(a) >>> b[4:0]);
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branchModel(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			3'd7: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	task automatic modelExec(input logic [31:0] w);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immI;
		logic [31:0] addrSum;
		logic [31:0] result;
		logic [31:0] next;
		logic writes;
		a = modelRegs[w[19:15]];
		b = modelRegs[w[24:20]];
		immI = {{20{w[31]}}, w[31:20]};
		addrSum = a + (w[6:0] == rvPkg::opStore ? {{20{w[31]}}, w[31:25], w[11:7]} : immI);
		result = '0;
		next = modelPc + 32'd4;
		writes = 1'b1;
		case (w[6:0])
			rvPkg::opR: result = aluModel(w[14:12], w[30], a, b);
			rvPkg::opIComp: result = aluModel(w[14:12], w[30] && w[14:12] == 3'd5, a, immI);
			rvPkg::opLoad: result = modelRam[addrSum[5:2]]; // word index wraps
			rvPkg::opStore: begin
				modelRam[addrSum[5:2]] = b;
				writes = 1'b0;
			end
			rvPkg::opBranch: begin
				if (branchModel(w[14:12], a, b))
					next = modelPc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
				writes = 1'b0;
			end
			rvPkg::opJal: begin
				result = modelPc + 32'd4;
				next = modelPc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			end
			rvPkg::opJalr: begin
				result = modelPc + 32'd4;
				next = (a + immI) & ~32'd1;
			end
			rvPkg::opLui: result = {w[31:12], 12'b0};
			rvPkg::opAuipc: result = modelPc + {w[31:12], 12'b0};
			default: writes = 1'b0;
		endcase
		if (writes && w[11:7] != 5'd0)
			modelRegs[w[11:7]] = result;
		modelPc = next;
	endtask

	task automatic execInstr(input logic [31:0] w);
		busCycle(1'b1, rvPkg::adrInstr, w, '0);
		modelExec(w);
	endtask

	initial begin
		logic [31:0] w;
		void'($urandom(32'hb89c_109c));
		rstN = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datIn = '0;
		expData = '0;
		testEnd = 1'b0;
		testIdx = 1;
		modelPc = '0;
		for (int k = 0; k < 32; k++)
			modelRegs[k] = '0;
		for (int k = 0; k < rvPkg::dataWords; k++)
			modelRam[k] = '0;
		repeat (8) @(negedge clk);
		rstN = 1'b1;

		readWord(rvPkg::adrPc);
		for (int k = 0; k < 32; k++)
			readReg(k);
		endTest();

		testIdx = 2;
		repeat (aluCount) begin
			w = $urandom;
			if ($urandom % 2) begin
				w[6:0] = rvPkg::opR;
				w[31:25] = {1'b0, w[30] && (w[14:12] == 3'd0 || w[14:12] == 3'd5), 5'b0};
			end else begin
				w[6:0] = rvPkg::opIComp;
				if (w[13:12] == 2'b01)
					w[31:25] = {1'b0, w[30], 5'b0}; // shifts by immediate
			end
			execInstr(w);
			readReg(w[11:7]);
			readReg(5'd0);
		end
		endTest();

		testIdx = 3;
		repeat (memCount) begin
			w = $urandom;
			w[6:0] = rvPkg::opLui;
			execInstr(w);
			readReg(w[11:7]);
			w = $urandom;
			w[6:0] = rvPkg::opAuipc;
			execInstr(w);
			readReg(w[11:7]);
			w = $urandom;
			w[6:0] = rvPkg::opStore;
			w[14:12] = 3'b010;
			execInstr(w);
			// load back from the address just stored
			w = {w[31:25], w[11:7], w[19:15], 3'b010, 5'($urandom), rvPkg::opLoad};
			execInstr(w);
			readReg(w[11:7]);
			w = $urandom;
			w[6:0] = rvPkg::opLoad;
			w[14:12] = 3'b010;
			execInstr(w);
			readReg(w[11:7]);
		end
		endTest();

		testIdx = 4;
		repeat (flowCount) begin
			w = $urandom;
			w[6:0] = rvPkg::opBranch;
			w[14:12] = branchF3[$urandom % 6];
			if ($urandom % 4 == 0)
				w[24:20] = w[19:15]; // equal operands
			execInstr(w);
			readWord(rvPkg::adrPc);
			w = $urandom;
			w[6:0] = rvPkg::opJal;
			execInstr(w);
			readWord(rvPkg::adrPc);
			readReg(w[11:7]);
			w = $urandom;
			w[6:0] = rvPkg::opJalr;
			w[14:12] = 3'b000;
			execInstr(w);
			readWord(rvPkg::adrPc);
			readReg(w[11:7]);
		end
		endTest();

		testIdx = 5;
		repeat (miscCount) begin
			w = $urandom & 32'hffff_fffc;
			busCycle(1'b1, rvPkg::adrPc, w, '0);
			modelPc = w;
			readWord(rvPkg::adrPc);
			w = $urandom;
			w[6:0] = rvPkg::opAuipc;
			execInstr(w);
			readReg(w[11:7]);
			busCycle(1'b1, rvPkg::adrRegBase + 5'($urandom), $urandom, '0); // ignored
			readWord(6'd2 + 6'($urandom % 30));
			w = $urandom;
			w[0] = 1'b0; // every RV32I opcode ends in 2'b11
			execInstr(w);
			readWord(rvPkg::adrPc);
			for (int k = 0; k < 32; k++)
				readReg(k);
		end
		endTest();

		@(negedge clk);
		$display("all tests done: %0d checks, %0d errors", checkCount, errCount);
		if (errCount == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
